// File: include/tlu_consts.svh
// TLU controller constants, included by every RTL file and the testbench that need them
`ifndef TLU_CONSTS_SVH
`define TLU_CONSTS_SVH

// register bus
`define TLU_ABUS_W          16
`define TLU_ADDR_VERSION    0
`define TLU_ADDR_MODE       1    // [1:0] mode, [2] msb first
`define TLU_ADDR_CYCLES     2    // [4:0] data clock cycles, [5] enable trigger reset
`define TLU_ADDR_TIMEOUT    3    // trigger low timeout in BUS_CLK cycles
`define TLU_ADDR_TRIGNUM    4    // read here first, 5 to 7 give the upper bytes
`define TLU_ADDR_LOST       8
`define TLU_VERSION         1

// trigger logic
`define TLU_DIVISOR         8    // BUS_CLK cycles per TLU_CLOCK period, even
`define TLU_FIFO_DEPTH      8    // power of two
`define TLU_WORD_MARK       31   // set in every trigger word

`endif

// File: hw/tlu_pkg.sv
// shared types of the TLU controller, used by scoped name from the RTL
`default_nettype none

package tlu_pkg;

    // handshake mode, as held in the mode register
    typedef enum logic [1:0] {
        disabled         = 2'b00,
        no_handshake     = 2'b01,
        simple_handshake = 2'b10,
        data_handshake   = 2'b11
    } tlu_mode_e;

    typedef enum logic [1:0] {
        idle,
        wait_low,      // busy set, waiting for the TLU to drop the trigger
        clock_data,    // shifting in the trigger number
        write_word
    } tlu_state_e;

endpackage

`default_nettype wire

// File: hw/tlu_cfg_if.sv
// configuration from the register bank to the trigger logic, one modport per consumer
`timescale 1ns/1ps
`default_nettype none

interface tlu_cfg_if;

    tlu_pkg::tlu_mode_e mode;
    logic               msb_first;
    logic [4:0]         clock_cycles;    // 0 means 32
    logic [7:0]         low_timeout;     // 0 disables the timeout
    logic               enable_reset;

    modport source (
        output mode,
        output msb_first,
        output clock_cycles,
        output low_timeout,
        output enable_reset
    );

    modport sel (input mode, input enable_reset);

    modport fsm (input mode);

    modport timer (input clock_cycles, input low_timeout);

    modport word (input mode, input msb_first, input clock_cycles);

endinterface

`default_nettype wire

// File: hw/tlu_regs.sv
// register bank of the TLU controller with registered byte reads and the trigger number snapshot
`timescale 1ns/1ps
`default_nettype none
`include "tlu_consts.svh"

module tlu_regs (
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  wire [`TLU_ABUS_W-1:0] BUS_ADD,
    input  wire [7:0]             BUS_DATA_IN,
    input  wire                   BUS_WR,
    output logic [7:0]            BUS_DATA_OUT,
    tlu_cfg_if.source             cfg,
    input  wire                   word_write,
    input  wire [31:0]            word,
    input  wire [7:0]             lost_cnt
);

    logic [7:0]  mode_reg;
    logic [7:0]  cycles_reg;
    logic [7:0]  timeout_reg;
    logic [31:0] last_word;      // most recent word sent to the FIFO
    logic [31:0] trignum_snap;   // frozen on the read of the low byte

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            mode_reg    <= 8'd0;   // disabled
            cycles_reg  <= 8'd0;   // 32 data bits
            timeout_reg <= 8'd0;
        end
        else if (BUS_WR)
        begin
            case (BUS_ADD)
                `TLU_ADDR_MODE:    mode_reg    <= BUS_DATA_IN;
                `TLU_ADDR_CYCLES:  cycles_reg  <= BUS_DATA_IN;
                `TLU_ADDR_TIMEOUT: timeout_reg <= BUS_DATA_IN;
                default: ;
            endcase
        end
    end

    assign cfg.mode         = tlu_pkg::tlu_mode_e'(mode_reg[1:0]);
    assign cfg.msb_first    = mode_reg[2];
    assign cfg.clock_cycles = cycles_reg[4:0];
    assign cfg.enable_reset = cycles_reg[5];
    assign cfg.low_timeout  = timeout_reg;

    always_ff @(posedge BUS_CLK)
    begin
        if (word_write)
            last_word <= word;
        if (BUS_ADD == `TLU_ADDR_TRIGNUM)
            trignum_snap <= last_word;   // bytes 5 to 7 then match byte 4
    end

    always_ff @(posedge BUS_CLK)
    begin
        case (BUS_ADD)
            `TLU_ADDR_VERSION:     BUS_DATA_OUT <= 8'(`TLU_VERSION);
            `TLU_ADDR_MODE:        BUS_DATA_OUT <= mode_reg;
            `TLU_ADDR_CYCLES:      BUS_DATA_OUT <= cycles_reg;
            `TLU_ADDR_TIMEOUT:     BUS_DATA_OUT <= timeout_reg;
            `TLU_ADDR_TRIGNUM:     BUS_DATA_OUT <= last_word[7:0];   // same value the snapshot takes
            `TLU_ADDR_TRIGNUM + 1: BUS_DATA_OUT <= trignum_snap[15:8];
            `TLU_ADDR_TRIGNUM + 2: BUS_DATA_OUT <= trignum_snap[23:16];
            `TLU_ADDR_TRIGNUM + 3: BUS_DATA_OUT <= trignum_snap[31:24];
            `TLU_ADDR_LOST:        BUS_DATA_OUT <= lost_cnt;
            default:               BUS_DATA_OUT <= 8'd0;
        endcase
    end

    // version visible on the cycle after the address
    a_version_read: assert property (@(posedge BUS_CLK)
        (BUS_ADD == `TLU_ADDR_VERSION) |=> (BUS_DATA_OUT == 8'(`TLU_VERSION)));

    // the mode seen by the trigger logic only moves on a bus write
    a_mode_stable: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(BUS_WR && BUS_ADD == `TLU_ADDR_MODE) |=> $stable(cfg.mode));

endmodule

`default_nettype wire

// File: hw/tlu_input_select.sv
// synchronises the RJ45 and LEMO pins, picks the active connector and flags trigger and reset edges
`timescale 1ns/1ps
`default_nettype none

module tlu_input_select (
    input  wire    BUS_CLK,
    input  wire    RST,
    input  wire    RJ45_TRIGGER,
    input  wire    LEMO_TRIGGER,
    input  wire    RJ45_RESET,
    input  wire    LEMO_RESET,
    tlu_cfg_if.sel cfg,
    output logic   RJ45_ENABLED,
    output wire    trigger,
    output logic   trigger_rise,
    output logic   trig_reset
);

    logic [3:0] pin_q1;      // {rj45 trigger, rj45 reset, lemo trigger, lemo reset}
    logic [3:0] pin_q2;
    logic       trigger_d;
    logic       reset_d;
    wire        reset_lvl;

    always_ff @(posedge BUS_CLK)
    begin
        pin_q1 <= {RJ45_TRIGGER, RJ45_RESET, LEMO_TRIGGER, LEMO_RESET};
        pin_q2 <= pin_q1;
    end

    // unplugged RJ45 pulls both lines high
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            RJ45_ENABLED <= 1'b0;
        else if (cfg.mode == tlu_pkg::disabled || (pin_q2[3] && pin_q2[2] && !RJ45_ENABLED))
            RJ45_ENABLED <= 1'b0;
        else
            RJ45_ENABLED <= 1'b1;
    end

    assign trigger   = RJ45_ENABLED ? pin_q2[3] : pin_q2[1];
    assign reset_lvl = RJ45_ENABLED ? pin_q2[2] : pin_q2[0];

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trigger_d    <= 1'b0;
            reset_d      <= 1'b0;
            trigger_rise <= 1'b0;
            trig_reset   <= 1'b0;
        end
        else
        begin
            trigger_d    <= trigger;
            reset_d      <= reset_lvl;
            trigger_rise <= trigger & ~trigger_d;
            trig_reset   <= reset_lvl & ~reset_d & cfg.enable_reset;
        end
    end

endmodule

`default_nettype wire

// File: hw/tlu_trigger_fsm.sv
// handshake FSM that answers the TLU, drives TLU_BUSY and steers the data clock and the FIFO write
`timescale 1ns/1ps
`default_nettype none

module tlu_trigger_fsm (
    input  wire    BUS_CLK,
    input  wire    RST,
    tlu_cfg_if.fsm cfg,
    input  wire    trigger,
    input  wire    trigger_rise,
    input  wire    bits_done,
    input  wire    timed_out,
    output logic   TLU_BUSY,
    output wire    clock_enable,
    output wire    timeout_enable,
    output wire    word_write
);

    tlu_pkg::tlu_state_e state;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            state    <= tlu_pkg::idle;
            TLU_BUSY <= 1'b0;
        end
        else
        begin
            case (state)
                tlu_pkg::idle:
                begin
                    if (trigger_rise)
                    begin
                        if (cfg.mode == tlu_pkg::no_handshake)
                            state <= tlu_pkg::write_word;   // busy stays low
                        else if (cfg.mode != tlu_pkg::disabled)
                        begin
                            state    <= tlu_pkg::wait_low;
                            TLU_BUSY <= 1'b1;
                        end
                    end
                end
                tlu_pkg::wait_low:
                begin
                    if (timed_out)
                    begin
                        state    <= tlu_pkg::idle;   // trigger stuck high, drop it
                        TLU_BUSY <= 1'b0;
                    end
                    else if (!trigger)
                    begin
                        if (cfg.mode == tlu_pkg::data_handshake)
                            state <= tlu_pkg::clock_data;
                        else
                            state <= tlu_pkg::write_word;
                    end
                end
                tlu_pkg::clock_data:
                begin
                    if (bits_done)
                        state <= tlu_pkg::write_word;
                end
                tlu_pkg::write_word:
                begin
                    state    <= tlu_pkg::idle;
                    TLU_BUSY <= 1'b0;   // falls as the word lands in the FIFO
                end
                default:
                begin
                    state    <= tlu_pkg::idle;
                    TLU_BUSY <= 1'b0;
                end
            endcase
        end
    end

    assign clock_enable   = (state == tlu_pkg::clock_data);
    assign timeout_enable = (state == tlu_pkg::wait_low);
    assign word_write     = (state == tlu_pkg::write_word);

    // data clock only runs inside a busy period
    a_clock_in_busy: assert property (@(posedge BUS_CLK) disable iff (RST)
        clock_enable |-> TLU_BUSY);

endmodule

`default_nettype wire

// File: hw/tlu_clock_timer.sv
// TLU_CLOCK divider with data bit count and the trigger low timeout counter
`timescale 1ns/1ps
`default_nettype none
`include "tlu_consts.svh"

module tlu_clock_timer (
    input  wire      BUS_CLK,
    input  wire      RST,
    tlu_cfg_if.timer cfg,
    input  wire      clock_enable,
    input  wire      timeout_enable,
    output logic     TLU_CLOCK,
    output wire      sample,
    output wire      bits_done,
    output wire      timed_out
);

    localparam int HALF  = `TLU_DIVISOR / 2;
    localparam int DIV_W = $clog2(`TLU_DIVISOR);

    logic [DIV_W-1:0] div_cnt;
    logic [5:0]       bit_cnt;
    logic [7:0]       low_cnt;
    wire  [5:0]       n_bits;
    wire              half_done;

    assign n_bits    = (cfg.clock_cycles == 5'd0) ? 6'd32 : {1'b0, cfg.clock_cycles};
    assign half_done = (div_cnt == DIV_W'(HALF - 1));

    // starts low, first edge is a rise
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || !clock_enable)
        begin
            div_cnt   <= '0;
            TLU_CLOCK <= 1'b0;
        end
        else if (half_done)
        begin
            div_cnt   <= '0;
            TLU_CLOCK <= ~TLU_CLOCK;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign sample = TLU_CLOCK & half_done;   // the high-to-low step

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || !clock_enable)
            bit_cnt <= 6'd0;
        else if (sample)
            bit_cnt <= bit_cnt + 6'd1;
    end

    assign bits_done = (bit_cnt == n_bits);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || !timeout_enable)
            low_cnt <= 8'd0;
        else if (!timed_out && low_cnt != 8'hff)
            low_cnt <= low_cnt + 8'd1;
    end

    assign timed_out = (cfg.low_timeout != 8'd0) && (low_cnt == cfg.low_timeout);

    // the FSM must not leave the clock phase while a sample is pending
    a_sample_enabled: assert property (@(posedge BUS_CLK) disable iff (RST)
        !clock_enable |-> !sample);

endmodule

`default_nettype wire

// File: hw/tlu_trigger_word.sv
// builds the 32-bit FIFO word from the shifted TLU number or the internal trigger count
`timescale 1ns/1ps
`default_nettype none
`include "tlu_consts.svh"

module tlu_trigger_word (
    input  wire     BUS_CLK,
    input  wire     RST,
    tlu_cfg_if.word cfg,
    input  wire     trigger,
    input  wire     sample,
    input  wire     word_write,
    input  wire     trig_reset,
    input  wire     clock_enable,
    output logic [31:0] word
);

    logic [31:0] shift_reg;
    logic        clock_enable_d;
    logic [30:0] trig_cnt;
    wire  [5:0]  n_bits;
    wire  [31:0] data_num;

    assign n_bits = (cfg.clock_cycles == 5'd0) ? 6'd32 : {1'b0, cfg.clock_cycles};

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            clock_enable_d <= 1'b0;
        else
            clock_enable_d <= clock_enable;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (clock_enable && !clock_enable_d)
            shift_reg <= 32'd0;   // fresh number each handshake
        else if (sample && cfg.msb_first)
            shift_reg <= {shift_reg[30:0], trigger};
        else if (sample)
            shift_reg <= {trigger, shift_reg[31:1]};
    end

    // lsb first leaves the number at the top, move it down
    assign data_num = cfg.msb_first ? shift_reg : (shift_reg >> (6'd32 - n_bits));

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || trig_reset)
            trig_cnt <= 31'd0;
        else if (word_write)
            trig_cnt <= trig_cnt + 31'd1;
    end

    always_comb
    begin
        word = {1'b0, (cfg.mode == tlu_pkg::data_handshake) ? data_num[30:0] : trig_cnt};
        word[`TLU_WORD_MARK] = 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/tlu_event_fifo.sv
// first-word-fall-through trigger word FIFO, drops words when full and counts them
`timescale 1ns/1ps
`default_nettype none
`include "tlu_consts.svh"

module tlu_event_fifo (
    input  wire         BUS_CLK,
    input  wire         RST,
    input  wire         word_write,
    input  wire  [31:0] word,
    input  wire         FIFO_READ,
    output wire         FIFO_EMPTY,
    output wire  [31:0] FIFO_DATA,
    output logic [7:0]  lost_cnt
);

    localparam int AW = $clog2(`TLU_FIFO_DEPTH);

    logic [31:0]   mem [`TLU_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;    // wraps, depth is a power of two
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    wire           full;
    wire           push;
    wire           pop;

    assign full = (count == (AW + 1)'(`TLU_FIFO_DEPTH));
    assign push = word_write & ~full;
    assign pop  = FIFO_READ & ~FIFO_EMPTY;

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            lost_cnt <= 8'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (word_write && full && lost_cnt != 8'hff)
                lost_cnt <= lost_cnt + 8'd1;   // saturates
        end
    end

    assign FIFO_EMPTY = (count == '0);
    assign FIFO_DATA  = mem[rd_ptr];   // head word, valid while not empty

    // reader has to wait for data
    a_no_empty_pop: assert property (@(posedge BUS_CLK) disable iff (RST)
        FIFO_READ |-> !FIFO_EMPTY);

endmodule

`default_nettype wire

// File: hw/tlu_controller.sv
// TLU controller top level, connects the register bank, trigger path and FIFO to the board pins
`timescale 1ns/1ps
`default_nettype none
`include "tlu_consts.svh"

module tlu_controller (
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  wire [`TLU_ABUS_W-1:0] BUS_ADD,
    input  wire [7:0]             BUS_DATA_IN,
    input  wire                   BUS_WR,
    output wire [7:0]             BUS_DATA_OUT,
    input  wire                   RJ45_TRIGGER,
    input  wire                   LEMO_TRIGGER,
    input  wire                   RJ45_RESET,
    input  wire                   LEMO_RESET,
    output wire                   RJ45_ENABLED,
    output wire                   TLU_BUSY,
    output wire                   TLU_CLOCK,
    input  wire                   FIFO_READ,
    output wire                   FIFO_EMPTY,
    output wire [31:0]            FIFO_DATA
);

    tlu_cfg_if cfg_if ();

    wire        trigger;
    wire        trigger_rise;
    wire        trig_reset;
    wire        clock_enable;
    wire        timeout_enable;
    wire        word_write;
    wire        sample;
    wire        bits_done;
    wire        timed_out;
    wire [31:0] word;
    wire [7:0]  lost_cnt;

    tlu_regs tlu_regs_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .BUS_ADD(BUS_ADD),
        .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_WR(BUS_WR),
        .BUS_DATA_OUT(BUS_DATA_OUT),
        .cfg(cfg_if.source),
        .word_write(word_write),
        .word(word),
        .lost_cnt(lost_cnt)
    );

    tlu_input_select tlu_input_select_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .RJ45_TRIGGER(RJ45_TRIGGER),
        .LEMO_TRIGGER(LEMO_TRIGGER),
        .RJ45_RESET(RJ45_RESET),
        .LEMO_RESET(LEMO_RESET),
        .cfg(cfg_if.sel),
        .RJ45_ENABLED(RJ45_ENABLED),
        .trigger(trigger),
        .trigger_rise(trigger_rise),
        .trig_reset(trig_reset)
    );

    tlu_trigger_fsm tlu_trigger_fsm_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .cfg(cfg_if.fsm),
        .trigger(trigger),
        .trigger_rise(trigger_rise),
        .bits_done(bits_done),
        .timed_out(timed_out),
        .TLU_BUSY(TLU_BUSY),
        .clock_enable(clock_enable),
        .timeout_enable(timeout_enable),
        .word_write(word_write)
    );

    tlu_clock_timer tlu_clock_timer_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .cfg(cfg_if.timer),
        .clock_enable(clock_enable),
        .timeout_enable(timeout_enable),
        .TLU_CLOCK(TLU_CLOCK),
        .sample(sample),
        .bits_done(bits_done),
        .timed_out(timed_out)
    );

    tlu_trigger_word tlu_trigger_word_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .cfg(cfg_if.word),
        .trigger(trigger),
        .sample(sample),
        .word_write(word_write),
        .trig_reset(trig_reset),
        .clock_enable(clock_enable),
        .word(word)
    );

    tlu_event_fifo tlu_event_fifo_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .word_write(word_write),
        .word(word),
        .FIFO_READ(FIFO_READ),
        .FIFO_EMPTY(FIFO_EMPTY),
        .FIFO_DATA(FIFO_DATA),
        .lost_cnt(lost_cnt)
    );

endmodule

`default_nettype wire

// File: tb/tb_tlu_controller.sv
// self-checking testbench for the TLU controller, plays a behavioural TLU through the stim file cases
`timescale 1ns/1ps
`default_nettype none
`include "tlu_consts.svh"

module tb_tlu_controller;

    localparam int N_FIELDS  = 10;   // hex words per stim line
    localparam int MAX_CASES = 32;

    typedef logic [`TLU_ABUS_W-1:0] addr_t;

    localparam addr_t A_VERSION = addr_t'(`TLU_ADDR_VERSION);
    localparam addr_t A_MODE    = addr_t'(`TLU_ADDR_MODE);
    localparam addr_t A_CYCLES  = addr_t'(`TLU_ADDR_CYCLES);
    localparam addr_t A_TIMEOUT = addr_t'(`TLU_ADDR_TIMEOUT);
    localparam addr_t A_TRIGNUM = addr_t'(`TLU_ADDR_TRIGNUM);
    localparam addr_t A_LOST    = addr_t'(`TLU_ADDR_LOST);

    logic        BUS_CLK;
    logic        RST;
    addr_t       BUS_ADD;
    logic [7:0]  BUS_DATA_IN;
    logic        BUS_WR;
    wire  [7:0]  BUS_DATA_OUT;
    logic        RJ45_TRIGGER;
    logic        LEMO_TRIGGER;
    logic        RJ45_RESET;
    logic        LEMO_RESET;
    wire         RJ45_ENABLED;
    wire         TLU_BUSY;
    wire         TLU_CLOCK;
    logic        FIFO_READ;
    wire         FIFO_EMPTY;
    wire  [31:0] FIFO_DATA;

    logic [31:0] stim [MAX_CASES * N_FIELDS];
    int          n_cases;
    logic        busy_forbidden;   // no handshake expected right now
    logic        use_lemo;

    tlu_controller tlu_controller_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .BUS_ADD(BUS_ADD),
        .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_WR(BUS_WR),
        .BUS_DATA_OUT(BUS_DATA_OUT),
        .RJ45_TRIGGER(RJ45_TRIGGER),
        .LEMO_TRIGGER(LEMO_TRIGGER),
        .RJ45_RESET(RJ45_RESET),
        .LEMO_RESET(LEMO_RESET),
        .RJ45_ENABLED(RJ45_ENABLED),
        .TLU_BUSY(TLU_BUSY),
        .TLU_CLOCK(TLU_CLOCK),
        .FIFO_READ(FIFO_READ),
        .FIFO_EMPTY(FIFO_EMPTY),
        .FIFO_DATA(FIFO_DATA)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #2 BUS_CLK = ~BUS_CLK;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timed out at %0t ns while waiting: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic bus_write(input addr_t addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD     <= addr;
        BUS_DATA_IN <= data;
        BUS_WR      <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    // data is registered, so it is taken one cycle after the address
    task automatic bus_read(input addr_t addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        data = BUS_DATA_OUT;
    endtask

    task automatic drive_trigger(input logic level);
        @(posedge BUS_CLK);
        if (use_lemo)
            LEMO_TRIGGER <= level;
        else
            RJ45_TRIGGER <= level;
    endtask

    task automatic pulse_reset();
        @(posedge BUS_CLK);
        if (use_lemo)
            LEMO_RESET <= 1'b1;
        else
            RJ45_RESET <= 1'b1;
        repeat (2) @(posedge BUS_CLK);
        if (use_lemo)
            LEMO_RESET <= 1'b0;
        else
            RJ45_RESET <= 1'b0;
        repeat (6) @(posedge BUS_CLK);   // 3 cycle pin to flag path plus margin
    endtask

    task automatic wait_busy(input logic level, input int max_cycles);
        int n;
        n = 0;
        @(negedge BUS_CLK);
        while (TLU_BUSY !== level)
        begin
            n++;
            if (n > max_cycles)
                give_up("TLU_BUSY never reached the expected level");
            @(negedge BUS_CLK);
        end
    endtask

    task automatic wait_not_empty(input int max_cycles);
        int n;
        n = 0;
        @(negedge BUS_CLK);
        while (FIFO_EMPTY)
        begin
            n++;
            if (n > max_cycles)
                give_up("no trigger word reached the FIFO");
            @(negedge BUS_CLK);
        end
    endtask

    task automatic wait_clock_rise(input int max_cycles);
        int   n;
        logic prev;
        n = 0;
        @(negedge BUS_CLK);
        prev = TLU_CLOCK;
        @(negedge BUS_CLK);
        while (!(TLU_CLOCK && !prev))
        begin
            n++;
            if (n > max_cycles)
                give_up("TLU_CLOCK did not rise for the next data bit");
            prev = TLU_CLOCK;
            @(negedge BUS_CLK);
        end
    endtask

    task automatic wait_last_number(input logic [7:0] number);
        logic [7:0] rd;
        int         n;
        n = 0;
        bus_read(A_TRIGNUM, rd);
        while (rd !== number)
        begin
            n++;
            if (n > 20)
                give_up("last trigger number on the bus did not update");
            bus_read(A_TRIGNUM, rd);
        end
    endtask

    // called mid-cycle with the head word on FIFO_DATA
    task automatic pop_word(input logic [31:0] expected, input string what);
        check_value("FIFO_EMPTY before read", 32'(FIFO_EMPTY), 32'd0);
        check_value(what, FIFO_DATA, expected);
        @(posedge BUS_CLK);
        FIFO_READ <= 1'b1;
        @(posedge BUS_CLK);
        FIFO_READ <= 1'b0;
        @(negedge BUS_CLK);
    endtask

    // disabled mode first so a cable swap cannot fire a trigger or a reset
    task automatic configure(input logic [1:0] mode, input logic msb, input logic [4:0] cycles,
                             input logic [7:0] timeout, input logic lemo, input logic rst_en);
        logic [7:0] rd;
        bus_write(A_MODE, 8'd0);
        bus_write(A_CYCLES, 8'd0);
        @(posedge BUS_CLK);
        use_lemo = lemo;
        RJ45_TRIGGER <= lemo;   // unplugged RJ45 reads high on both pins
        RJ45_RESET   <= lemo;
        LEMO_TRIGGER <= 1'b0;
        LEMO_RESET   <= 1'b0;
        repeat (4) @(posedge BUS_CLK);
        bus_write(A_MODE, {5'd0, msb, mode});
        bus_write(A_CYCLES, {2'd0, rst_en, cycles});
        bus_write(A_TIMEOUT, timeout);
        bus_read(A_MODE, rd);
        check_value("mode register", 32'(rd), 32'({5'd0, msb, mode}));
        bus_read(A_CYCLES, rd);
        check_value("cycles register", 32'(rd), 32'({2'd0, rst_en, cycles}));
        bus_read(A_TIMEOUT, rd);
        check_value("timeout register", 32'(rd), 32'(timeout));
        check_value("RJ45_ENABLED", 32'(RJ45_ENABLED), 32'(!lemo && mode != 2'd0));
    endtask

    task automatic run_case(input int idx);
        int          base;
        logic [1:0]  mode;
        logic        msb;
        logic [4:0]  cycles;
        logic        lemo;
        logic [31:0] number;
        int          hold;
        logic        want_word;
        logic [31:0] exp_word;
        int          n_bits;
        int          bit_idx;
        base      = idx * N_FIELDS;
        mode      = stim[base][1:0];
        msb       = stim[base + 1][0];
        cycles    = stim[base + 2][4:0];
        // disabled mode never selects RJ45, so the trigger goes on the LEMO pin
        lemo      = stim[base + 4][0] | (mode == 2'd0);
        number    = stim[base + 6];
        hold      = int'(stim[base + 7]);
        want_word = stim[base + 8][0];
        exp_word  = {1'b0, stim[base + 9][30:0]};
        exp_word[`TLU_WORD_MARK] = 1'b1;
        configure(mode, msb, cycles, stim[base + 3][7:0], lemo, stim[base + 5][0]);
        if (stim[base + 5][0])
            pulse_reset();
        busy_forbidden = (mode == 2'd0 || mode == 2'd1);
        drive_trigger(1'b1);
        if (mode == 2'd2 || mode == 2'd3)
        begin
            wait_busy(1'b1, 10);
            repeat (hold) @(posedge BUS_CLK);
            drive_trigger(1'b0);
            if (mode == 2'd3)
            begin
                n_bits = (cycles == 5'd0) ? 32 : int'(cycles);
                for (int k = 0; k < n_bits; k++)
                begin
                    bit_idx = msb ? n_bits - 1 - k : k;
                    wait_clock_rise(2 * `TLU_DIVISOR);
                    drive_trigger(number[bit_idx]);   // TLU sets data after the rise
                end
            end
            wait_busy(1'b0, 400);   // word lands with the falling busy
        end
        else
        begin
            repeat (hold) @(posedge BUS_CLK);
            drive_trigger(1'b0);
            if (want_word)
                wait_not_empty(20);
            else
            begin
                repeat (20) @(posedge BUS_CLK);
                @(negedge BUS_CLK);
            end
        end
        check_value("FIFO_EMPTY after trigger", 32'(FIFO_EMPTY), 32'(!want_word));
        if (want_word)
            pop_word(exp_word, "trigger word");
        check_value("FIFO_EMPTY after read", 32'(FIFO_EMPTY), 32'd1);
        drive_trigger(1'b0);
        busy_forbidden = 1'b0;
    endtask

    // one word more than the FIFO holds, nothing read until the end
    task automatic overflow_phase();
        logic [7:0]  rd;
        logic [31:0] last;
        logic [31:0] exp_word;
        configure(2'd1, 1'b0, 5'd0, 8'd0, 1'b0, 1'b1);
        pulse_reset();
        for (int k = 0; k <= `TLU_FIFO_DEPTH; k++)
        begin
            drive_trigger(1'b1);
            repeat (2) @(posedge BUS_CLK);
            drive_trigger(1'b0);
            if (k == 0)
                wait_not_empty(20);   // previous case may also have left number 0
            else
                wait_last_number(8'(k));
        end
        bus_read(A_LOST, rd);
        check_value("lost word count", 32'(rd), 32'd1);
        bus_read(A_TRIGNUM, rd);
        last[7:0] = rd;
        bus_read(A_TRIGNUM + addr_t'(1), rd);
        last[15:8] = rd;
        bus_read(A_TRIGNUM + addr_t'(2), rd);
        last[23:16] = rd;
        bus_read(A_TRIGNUM + addr_t'(3), rd);
        last[31:24] = rd;
        exp_word = 32'(`TLU_FIFO_DEPTH);
        exp_word[`TLU_WORD_MARK] = 1'b1;
        check_value("last trigger number", last, exp_word);
        for (int k = 0; k < `TLU_FIFO_DEPTH; k++)
        begin
            exp_word = 32'(k);
            exp_word[`TLU_WORD_MARK] = 1'b1;
            pop_word(exp_word, "buffered trigger word");
        end
        check_value("FIFO_EMPTY after draining", 32'(FIFO_EMPTY), 32'd1);
    endtask

    always @(negedge BUS_CLK)
    begin
        if (!RST)
        begin
            check_value("TLU_CLOCK while not busy", 32'(TLU_CLOCK & ~TLU_BUSY), 32'd0);
            check_value("TLU_BUSY without handshake", 32'(busy_forbidden & TLU_BUSY), 32'd0);
        end
    end

    initial
    begin
        #1;
        repeat (n_cases * 600) @(posedge BUS_CLK);
        $display("Run stopped by the watchdog after %0d cycles", n_cases * 600);
        $display("Test failed");
        $fatal(1);
    end

    initial
    begin
        logic [7:0] rd;
        RST            = 1'b1;
        BUS_ADD        = '0;
        BUS_DATA_IN    = 8'd0;
        BUS_WR         = 1'b0;
        RJ45_TRIGGER   = 1'b0;
        LEMO_TRIGGER   = 1'b0;
        RJ45_RESET     = 1'b0;
        LEMO_RESET     = 1'b0;
        FIFO_READ      = 1'b0;
        busy_forbidden = 1'b0;
        use_lemo       = 1'b0;
        for (int i = 0; i < MAX_CASES * N_FIELDS; i++)
            stim[i] = '1;   // marks unused lines
        $readmemh("tb/tlu_stim.txt", stim);
        n_cases = 0;
        while (n_cases < MAX_CASES && stim[n_cases * N_FIELDS] !== 32'hffff_ffff)
            n_cases++;
        if (n_cases == 0)
        begin
            $display("No trigger cases could be read from tb/tlu_stim.txt");
            $display("Test failed");
            $fatal(1);
        end
        repeat (8) @(posedge BUS_CLK);
        RST <= 1'b0;
        @(negedge BUS_CLK);
        check_value("TLU_BUSY after reset", 32'(TLU_BUSY), 32'd0);
        check_value("TLU_CLOCK after reset", 32'(TLU_CLOCK), 32'd0);
        check_value("RJ45_ENABLED after reset", 32'(RJ45_ENABLED), 32'd0);
        check_value("FIFO_EMPTY after reset", 32'(FIFO_EMPTY), 32'd1);
        bus_read(A_VERSION, rd);
        check_value("version", 32'(rd), 32'(`TLU_VERSION));
        for (int i = 0; i < n_cases; i++)
            run_case(i);
        overflow_phase();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tlu_stim.txt
// mode msb_first clock_cycles low_timeout lemo trig_reset trigger_number hold expect_word number
// all hex; lemo 1 leaves RJ45 unplugged, number is the expected count or data in the word
1 0 00 00 0 0 00000000 03 1 00000000 // no handshake
1 0 00 00 0 0 00000000 03 1 00000001
2 0 00 00 0 0 00000000 05 1 00000002 // simple handshake
2 0 00 00 1 0 00000000 05 1 00000003
3 0 08 00 0 0 000000a5 04 1 000000a5 // data handshake, lsb first
3 1 08 00 0 0 0000003c 04 1 0000003c
3 1 10 00 1 0 0000beef 04 1 0000beef
3 0 0c 00 0 0 00000abc 04 1 00000abc
3 0 00 00 0 0 dead1234 04 1 5ead1234 // 32 bits, top bit dropped
3 1 00 00 0 0 87654321 04 1 07654321
2 0 00 14 0 0 00000000 3c 0 00000000 // trigger stuck high, timeout
2 0 00 14 0 0 00000000 04 1 0000000a
0 0 00 00 0 0 00000000 04 0 00000000 // disabled
1 0 00 00 1 1 00000000 03 1 00000000 // count restarts after reset pulse
2 0 00 00 0 1 00000000 03 1 00000000

// File: list.f
+incdir+include
hw/tlu_pkg.sv
hw/tlu_cfg_if.sv
hw/tlu_regs.sv
hw/tlu_input_select.sv
hw/tlu_trigger_fsm.sv
hw/tlu_clock_timer.sv
hw/tlu_trigger_word.sv
hw/tlu_event_fifo.sv
hw/tlu_controller.sv
tb/tb_tlu_controller.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f list.f --top-module tb_tlu_controller -o sim_tlu \
    && ./obj_dir/sim_tlu \
    || exit 1
